// File: hw/aemb_defines.svh
// AEMB core global widths, register count and reset vector
`ifndef AEMB_DEFINES_SVH
`define AEMB_DEFINES_SVH

// Datapath and bus word width
`define AEMB_DW 32

// Architectural registers, r0 hardwired to zero
`define AEMB_NREG 32

// Major opcode field, instruction bits 31 to 26
`define AEMB_OPW 6

// First instruction fetch address after reset
`define AEMB_RESET_PC 32'h0000_0000

// Instruction field positions
`define AEMB_OPC_LSB 26
`define AEMB_RD_LSB 21
`define AEMB_RA_LSB 16
`define AEMB_RB_LSB 11

// Width of the raw immediate field
`define AEMB_IMMW 16

`endif

// File: hw/aembIsaPkg.sv
// AEMB instruction set types, opcode encodings and the decoded control word
`include "aemb_defines.svh"

package aembIsaPkg;

  typedef logic [$clog2(`AEMB_NREG)-1:0] regIdx_t;  // Register number
  typedef logic [`AEMB_DW-1:0] simm_t;              // Sign-extended immediate

  // Major opcodes of the supported subset
  // Bit 3 set marks the immediate form of the ALU ops
  typedef enum logic [`AEMB_OPW-1:0] {
    OP_ADD    = 6'b000000,  // rD = rA + rB
    OP_RSUB   = 6'b000001,  // rD = rB - rA
    OP_ADDI   = 6'b001000,
    OP_RSUBI  = 6'b001001,
    OP_OR     = 6'b100000,
    OP_AND    = 6'b100001,
    OP_XOR    = 6'b100010,
    OP_ORI    = 6'b101000,
    OP_ANDI   = 6'b101001,
    OP_XORI   = 6'b101010,
    OP_BRI    = 6'b101110,  // Unconditional, pc relative
    OP_BCONDI = 6'b101111,  // rD field picks eq or ne
    OP_LWI    = 6'b111010,  // Word load, rA + imm
    OP_SWI    = 6'b111110   // Word store of rD
  } opcode_t;

  // ALU function select
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_RSUB,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_PASS  // Operand B straight through
  } aluOp_t;

  // Control word handed from decode to execute
  typedef struct packed {
    aluOp_t  aluOp;
    logic    useImm;        // Operand B is the immediate
    logic    wrEn;          // Result goes back to rd
    regIdx_t rd;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logic    branchIfZero;  // Taken on rA == 0, else on rA != 0
    simm_t   imm;
    regIdx_t ra;
    regIdx_t rb;            // Holds rd for stores
  } ctrl_t;

endpackage

// File: hw/aembBusPkg.sv
// AEMB memory port types for the instruction and data sides
`include "aemb_defines.svh"

package aembBusPkg;

  typedef logic [`AEMB_DW-1:0] word_t;  // Data or instruction word
  typedef logic [`AEMB_DW-1:0] addr_t;  // Byte address

  // Instruction side request
  // Address always word aligned
  typedef struct packed {
    logic  en;    // Fetch wanted this cycle
    addr_t addr;
  } imemReq_t;

  // Data side request
  // Write data only meaningful with we set
  typedef struct packed {
    logic  en;    // Access wanted this cycle
    logic  we;    // Store when set, load otherwise
    addr_t addr;
    word_t data;
  } dmemReq_t;

  // Handshake
  // Request holds while ready is low
  // Read data valid in the cycle ready is high
  // Write taken on the edge that closes a ready cycle

endpackage

// File: hw/aembFetch.sv
// AEMB fetch unit holding the program counter and fetch register, with branch redirect
`timescale 1ns/1ps
`include "aemb_defines.svh"

module aembFetch
  import aembBusPkg::*;
(
  input  logic     sysClk_i,
  input  logic     arstN_i,
  input  logic     en_i,            // Global pipeline enable
  input  logic     branchTaken_i,
  input  addr_t    branchTarget_i,
  output imemReq_t imemReq_o,
  input  word_t    imemData_i,
  output word_t    instr_o,
  output addr_t    pc_o,            // Address of instr_o
  output logic     instrValid_o
);

  logic  reqEn;      // Off through reset, on from the first edge after
  addr_t pcReq;      // Next sequential fetch address
  addr_t fetchAddr;
  logic  capture;
  word_t instrReg;
  addr_t pcReg;
  logic  validReg;

  // Redirect straight onto the bus so the target is fetched in the branch cycle
  assign fetchAddr = branchTaken_i ? branchTarget_i : pcReq;

  assign imemReq_o.en   = reqEn;
  assign imemReq_o.addr = fetchAddr;

  assign capture = en_i & reqEn;

  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      reqEn    <= 1'b0;
      pcReq    <= `AEMB_RESET_PC;
      validReg <= 1'b0;
    end else begin
      reqEn <= 1'b1;
      if (capture) begin
        pcReq    <= fetchAddr + 32'd4;
        validReg <= 1'b1;
      end
    end
  end

  // Fetched word and its address
  always_ff @(posedge sysClk_i) begin
    if (capture) begin
      instrReg <= imemData_i;
      pcReg    <= fetchAddr;
    end
  end

  assign instr_o = instrReg;
  assign pc_o    = pcReg;

  // Word behind a taken branch turns into a bubble
  assign instrValid_o = validReg & ~branchTaken_i;

endmodule

// File: hw/aembDecode.sv
// AEMB decoder turning the fetched word into a registered control word, with load stall
`timescale 1ns/1ps
`include "aemb_defines.svh"

module aembDecode
  import aembIsaPkg::*;
  import aembBusPkg::*;
(
  input  logic  sysClk_i,
  input  logic  arstN_i,
  input  logic  en_i,          // Both memories ready
  input  word_t instr_i,
  input  addr_t pc_i,
  input  logic  instrValid_i,
  output ctrl_t ctrl_o,
  output addr_t pcD_o,
  output logic  loadStall_o
);

  opcode_t opc;
  regIdx_t rdF;
  regIdx_t raF;
  regIdx_t rbF;
  simm_t   immExt;
  logic    immForm;
  ctrl_t   ctrlNext;
  logic    loadSecond;  // Load already spent its stall cycle
  logic    advance;

  // Write disabled, no memory or branch side effects
  function automatic ctrl_t nopCtrl();
    ctrl_t c;
    c       = '0;
    c.aluOp = ALU_PASS;
    return c;
  endfunction

  assign opc     = opcode_t'(instr_i[`AEMB_OPC_LSB +: `AEMB_OPW]);
  assign rdF     = instr_i[`AEMB_RD_LSB +: $bits(regIdx_t)];
  assign raF     = instr_i[`AEMB_RA_LSB +: $bits(regIdx_t)];
  assign rbF     = instr_i[`AEMB_RB_LSB +: $bits(regIdx_t)];
  assign immExt  = {{(`AEMB_DW-`AEMB_IMMW){instr_i[`AEMB_IMMW-1]}}, instr_i[`AEMB_IMMW-1:0]};
  assign immForm = instr_i[`AEMB_OPC_LSB+3];  // Opcode bit 3

  always_comb begin
    ctrlNext     = nopCtrl();
    ctrlNext.rd  = rdF;
    ctrlNext.ra  = raF;
    ctrlNext.rb  = rbF;
    ctrlNext.imm = immExt;
    if (instrValid_i) begin
      case (opc)
        OP_ADD, OP_ADDI: begin
          ctrlNext.aluOp  = ALU_ADD;
          ctrlNext.useImm = immForm;
          ctrlNext.wrEn   = 1'b1;
        end
        OP_RSUB, OP_RSUBI: begin
          ctrlNext.aluOp  = ALU_RSUB;
          ctrlNext.useImm = immForm;
          ctrlNext.wrEn   = 1'b1;
        end
        OP_OR, OP_ORI: begin
          ctrlNext.aluOp  = ALU_OR;
          ctrlNext.useImm = immForm;
          ctrlNext.wrEn   = 1'b1;
        end
        OP_AND, OP_ANDI: begin
          ctrlNext.aluOp  = ALU_AND;
          ctrlNext.useImm = immForm;
          ctrlNext.wrEn   = 1'b1;
        end
        OP_XOR, OP_XORI: begin
          ctrlNext.aluOp  = ALU_XOR;
          ctrlNext.useImm = immForm;
          ctrlNext.wrEn   = 1'b1;
        end
        OP_BRI: begin
          // Test r0 for zero, always true
          ctrlNext.isBranch     = 1'b1;
          ctrlNext.branchIfZero = 1'b1;
          ctrlNext.ra           = '0;
        end
        OP_BCONDI: begin
          ctrlNext.isBranch     = 1'b1;
          ctrlNext.branchIfZero = (rdF == '0);  // beqi, anything else as bnei
        end
        OP_LWI: begin
          ctrlNext.aluOp  = ALU_ADD;  // Address from the ALU
          ctrlNext.useImm = 1'b1;
          ctrlNext.wrEn   = 1'b1;
          ctrlNext.isLoad = 1'b1;
        end
        OP_SWI: begin
          ctrlNext.aluOp   = ALU_ADD;
          ctrlNext.useImm  = 1'b1;
          ctrlNext.isStore = 1'b1;
          ctrlNext.rb      = rdF;     // Store data read on port B
        end
        default: ;                   // Unknown opcode stays a no-op
      endcase
    end
  end

  // Stall cycle is the first cycle a load spends in execute
  assign loadStall_o = ctrl_o.isLoad & ~loadSecond;
  assign advance     = en_i & ~loadStall_o;

  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      ctrl_o     <= nopCtrl();
      loadSecond <= 1'b0;
    end else if (loadStall_o) begin
      loadSecond <= 1'b1;             // Hold the load for its second cycle
    end else if (advance) begin
      ctrl_o     <= ctrlNext;
      loadSecond <= 1'b0;
    end
  end

  always_ff @(posedge sysClk_i) begin
    if (advance) pcD_o <= pc_i;
  end

endmodule

// File: hw/aembRegFile.sv
// AEMB register file with two combinational read ports and a buffered write port
`timescale 1ns/1ps
`include "aemb_defines.svh"

module aembRegFile
  import aembIsaPkg::*;
  import aembBusPkg::*;
(
  input  logic    sysClk_i,
  input  logic    arstN_i,
  input  regIdx_t rdIdxA_i,
  input  regIdx_t rdIdxB_i,
  output word_t   rdDataA_o,
  output word_t   rdDataB_o,
  input  logic    wrEn_i,
  input  regIdx_t wrIdx_i,
  input  word_t   wrData_i
);

  word_t   regs [`AEMB_NREG];
  logic    bufEn;    // Write waiting to land in the array
  regIdx_t bufIdx;
  word_t   bufData;

  // Write buffer keeps the array update off the execute path
  always_ff @(posedge sysClk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      bufEn   <= 1'b0;
      bufIdx  <= '0;
      bufData <= '0;
      for (int i = 0; i < `AEMB_NREG; i++) regs[i] <= '0;
    end else begin
      bufEn   <= wrEn_i & (wrIdx_i != '0);  // r0 never written
      bufIdx  <= wrIdx_i;
      bufData <= wrData_i;
      if (bufEn) regs[bufIdx] <= bufData;
    end
  end

  // Buffered write wins over the stale array entry
  function automatic word_t readPort(regIdx_t idx);
    word_t val;
    if (idx == '0) val = '0;
    else if (bufEn && (bufIdx == idx)) val = bufData;
    else val = regs[idx];
    return val;
  endfunction

  assign rdDataA_o = readPort(rdIdxA_i);
  assign rdDataB_o = readPort(rdIdxB_i);

endmodule

// File: hw/aembExecute.sv
// AEMB execute unit with ALU, branch resolve, data memory access and writeback select
`timescale 1ns/1ps

module aembExecute
  import aembIsaPkg::*;
  import aembBusPkg::*;
(
  input  logic     en_i,            // Global pipeline enable
  input  ctrl_t    ctrl_i,
  input  addr_t    pc_i,            // Address of this instruction
  input  word_t    opA_i,
  input  word_t    opB_i,
  input  logic     loadStall_i,
  output dmemReq_t dmemReq_o,
  input  word_t    dmemData_i,
  output logic     wrEn_o,
  output regIdx_t  wrIdx_o,
  output word_t    wrData_o,
  output logic     branchTaken_o,
  output addr_t    branchTarget_o
);

  word_t aluB;
  word_t aluRes;
  logic  opAZero;

  assign aluB = ctrl_i.useImm ? ctrl_i.imm : opB_i;

  always_comb begin
    case (ctrl_i.aluOp)
      ALU_ADD:  aluRes = opA_i + aluB;
      ALU_RSUB: aluRes = aluB - opA_i;  // Reverse subtract
      ALU_OR:   aluRes = opA_i | aluB;
      ALU_AND:  aluRes = opA_i & aluB;
      ALU_XOR:  aluRes = opA_i ^ aluB;
      default:  aluRes = aluB;
    endcase
  end

  // Branches, BRI comes in as a zero test on r0
  assign opAZero        = (opA_i == '0);
  assign branchTaken_o  = ctrl_i.isBranch & (opAZero == ctrl_i.branchIfZero);
  assign branchTarget_o = pc_i + ctrl_i.imm;

  // Load address settles in the stall cycle, request goes out in the second
  assign dmemReq_o.en   = ctrl_i.isStore | (ctrl_i.isLoad & ~loadStall_i);
  assign dmemReq_o.we   = ctrl_i.isStore;
  assign dmemReq_o.addr = aluRes;  // rA + imm
  assign dmemReq_o.data = opB_i;   // rD on port B

  // Writeback
  assign wrEn_o   = en_i & ctrl_i.wrEn;
  assign wrIdx_o  = ctrl_i.rd;
  assign wrData_o = ctrl_i.isLoad ? dmemData_i : aluRes;

endmodule

// File: hw/aembCore.sv
// AEMB core top joining fetch, decode, register file and execute under one enable
`timescale 1ns/1ps

module aembCore
  import aembIsaPkg::*;
  import aembBusPkg::*;
(
  input  logic     sysClk_i,
  input  logic     arstN_i,
  output imemReq_t imemReq_o,
  input  word_t    imemData_i,
  input  logic     imemReady_i,
  output dmemReq_t dmemReq_o,
  input  word_t    dmemData_i,
  input  logic     dmemReady_i
);

  logic    memEn;        // Both memories done this cycle
  logic    gEn;          // Global pipeline enable
  logic    loadStall;
  word_t   instrF;
  addr_t   pcF;
  logic    validF;
  ctrl_t   ctrlD;
  addr_t   pcD;
  word_t   opA;
  word_t   opB;
  logic    wrEn;
  regIdx_t wrIdx;
  word_t   wrData;
  logic    branchTaken;
  addr_t   branchTarget;

  assign memEn = imemReady_i & dmemReady_i;
  assign gEn   = memEn & ~loadStall;

  aembFetch i_aembFetch (
    .sysClk_i       (sysClk_i),
    .arstN_i        (arstN_i),
    .en_i           (gEn),
    .branchTaken_i  (branchTaken),
    .branchTarget_i (branchTarget),
    .imemReq_o      (imemReq_o),
    .imemData_i     (imemData_i),
    .instr_o        (instrF),
    .pc_o           (pcF),
    .instrValid_o   (validF)
  );

  // Decode gates its own advance with the load stall
  aembDecode i_aembDecode (
    .sysClk_i     (sysClk_i),
    .arstN_i      (arstN_i),
    .en_i         (memEn),
    .instr_i      (instrF),
    .pc_i         (pcF),
    .instrValid_i (validF),
    .ctrl_o       (ctrlD),
    .pcD_o        (pcD),
    .loadStall_o  (loadStall)
  );

  aembRegFile i_aembRegFile (
    .sysClk_i  (sysClk_i),
    .arstN_i   (arstN_i),
    .rdIdxA_i  (ctrlD.ra),
    .rdIdxB_i  (ctrlD.rb),
    .rdDataA_o (opA),
    .rdDataB_o (opB),
    .wrEn_i    (wrEn),
    .wrIdx_i   (wrIdx),
    .wrData_i  (wrData)
  );

  aembExecute i_aembExecute (
    .en_i           (gEn),
    .ctrl_i         (ctrlD),
    .pc_i           (pcD),
    .opA_i          (opA),
    .opB_i          (opB),
    .loadStall_i    (loadStall),
    .dmemReq_o      (dmemReq_o),
    .dmemData_i     (dmemData_i),
    .wrEn_o         (wrEn),
    .wrIdx_o        (wrIdx),
    .wrData_o       (wrData),
    .branchTaken_o  (branchTaken),
    .branchTarget_o (branchTarget)
  );

endmodule

// File: testbench/aembCore_sva.sv
// AEMB core checks on memory request stability, reset behavior and the load stall
`timescale 1ns/1ps

module aembCoreSva
  import aembBusPkg::*;
(
  input logic     sysClk_i,
  input logic     arstN_i,
  input imemReq_t imemReq_i,
  input logic     imemReady_i,
  input dmemReq_t dmemReq_i,
  input logic     dmemReady_i,
  input logic     loadStall_i
);

  int failCount;  // Summed into the testbench result

  initial failCount = 0;

  // Fetch request frozen while the instruction side stalls
  imemHold: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    imemReq_i.en && !imemReady_i |=> $stable(imemReq_i))
    else begin
      failCount++;
      $error("Instruction request changed while its ready was low");
    end

  dmemHold: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    dmemReq_i.en && !dmemReady_i |=> $stable(dmemReq_i))
    else begin
      failCount++;
      $error("Data request changed while its ready was low");
    end

  // Quiet ports in reset and on the release edge
  resetQuiet: assert property (@(posedge sysClk_i)
    !arstN_i || $rose(arstN_i) |-> !imemReq_i.en && !dmemReq_i.en)
    else begin
      failCount++;
      $error("Memory request enabled during or at release of reset");
    end

  stallOnce: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    loadStall_i |=> !loadStall_i)
    else begin
      failCount++;
      $error("Load stall held for two cycles");
    end

  fetchAlign: assert property (@(posedge sysClk_i) disable iff (!arstN_i)
    imemReq_i.en |-> imemReq_i.addr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("Fetch address not word aligned");
    end

endmodule

// File: testbench/tbAembCore.sv
// Testbench for the AEMB core running a fixed program against randomly stalling memories
`timescale 1ns/1ps

module tbAembCore
  import aembIsaPkg::*;
  import aembBusPkg::*;
();

  localparam int          ClkPeriod  = 40;
  localparam int          MaxCycles  = 2000;      // ~50 instr, few cycles each with stalls
  localparam logic [15:0] DataBase   = 16'h0080;  // First store slot
  localparam regIdx_t     PoisonReg  = 5'd31;
  localparam logic [15:0] PoisonAddr = 16'h01F0;  // Never expected

  logic     sysClk;
  logic     arstN;
  imemReq_t imemReq;
  word_t    imemData;
  logic     imemReady;
  dmemReq_t dmemReq;
  word_t    dmemData;
  logic     dmemReady;

  word_t       imem [64];
  word_t       dmem [128];
  word_t       refReg [32];   // Register values by the ISA rules
  word_t       refMem [128];
  logic [5:0]  nInstr;
  logic [15:0] nextSlot;
  addr_t       expAddr [$];   // Expected stores in program order
  word_t       expData [$];
  int          errCount;
  int          storeCount;
  int          cycleCount;
  int          svaFails;
  int          seed;

  aembCore i_aembCore (
    .sysClk_i    (sysClk),
    .arstN_i     (arstN),
    .imemReq_o   (imemReq),
    .imemData_i  (imemData),
    .imemReady_i (imemReady),
    .dmemReq_o   (dmemReq),
    .dmemData_i  (dmemData),
    .dmemReady_i (dmemReady)
  );

  bind aembCore aembCoreSva i_aembCoreSva (
    .sysClk_i    (sysClk_i),
    .arstN_i     (arstN_i),
    .imemReq_i   (imemReq_o),
    .imemReady_i (imemReady_i),
    .dmemReq_i   (dmemReq_o),
    .dmemReady_i (dmemReady_i),
    .loadStall_i (loadStall)
  );

  // Memories answer from the current request address
  assign imemData = imem[imemReq.addr[7:2]];
  assign dmemData = dmem[dmemReq.addr[8:2]];

  initial begin
    sysClk = 1'b0;
    forever #(ClkPeriod / 2) sysClk = ~sysClk;
  end

  // Either side drops ready about one cycle in four
  initial begin
    seed = 98236;
    imemReady <= 1'b0;
    dmemReady <= 1'b0;
    forever begin
      @(posedge sysClk);
      imemReady <= ($random(seed) & 3) != 0;
      dmemReady <= ($random(seed) & 3) != 0;
    end
  end

  function automatic word_t encode(opcode_t op, regIdx_t rd, regIdx_t ra, logic [15:0] low);
    return {op, rd, ra, low};
  endfunction

  function automatic word_t expectedAlu(opcode_t op, word_t a, word_t b);
    case (op)
      OP_ADD, OP_ADDI:   return a + b;
      OP_RSUB, OP_RSUBI: return b - a;  // Reverse subtract
      OP_OR, OP_ORI:     return a | b;
      OP_AND, OP_ANDI:   return a & b;
      default:           return a ^ b;
    endcase
  endfunction

  task automatic place(word_t w);
    imem[nInstr] = w;
    nInstr = nInstr + 6'd1;
  endtask

  task automatic aluReg(opcode_t op, regIdx_t rd, regIdx_t ra, regIdx_t rb);
    place(encode(op, rd, ra, {rb, 11'd0}));
    if (rd != '0) refReg[rd] = expectedAlu(op, refReg[ra], refReg[rb]);
  endtask

  task automatic aluImm(opcode_t op, regIdx_t rd, regIdx_t ra, logic [15:0] imm);
    word_t ext;
    ext = {{16{imm[15]}}, imm};  // Always sign extended, no IMM prefix
    place(encode(op, rd, ra, imm));
    if (rd != '0) refReg[rd] = expectedAlu(op, refReg[ra], ext);
  endtask

  // Store rd to the next free slot, based on r0
  task automatic storeWord(regIdx_t rd);
    place(encode(OP_SWI, rd, 5'd0, nextSlot));
    expAddr.push_back({16'h0000, nextSlot});
    expData.push_back(refReg[rd]);
    refMem[nextSlot[8:2]] = refReg[rd];
    nextSlot = nextSlot + 16'd4;
  endtask

  task automatic loadWord(regIdx_t rd, logic [15:0] addr);
    place(encode(OP_LWI, rd, 5'd0, addr));
    if (rd != '0) refReg[rd] = refMem[addr[8:2]];
  endtask

  // Branch two words on; a taken one hides a poison store
  task automatic branchOver(opcode_t op, regIdx_t cond, regIdx_t ra);
    logic taken;
    taken = (op == OP_BRI) || ((refReg[ra] == '0) == (cond == '0));
    place(encode(op, cond, ra, 16'd8));
    if (taken) place(encode(OP_SWI, PoisonReg, 5'd0, PoisonAddr));
    else storeWord(ra);  // Fall through path
  endtask

  task automatic checkStore(addr_t addr, word_t data);
    assert (addr == expAddr[0])
      else begin
        errCount++;
        $display("Fail dmemReq_o.addr: got %h, expected %h", addr, expAddr[0]);
      end
    assert (data == expData[0])
      else begin
        errCount++;
        $display("Fail dmemReq_o.data: got %h, expected %h", data, expData[0]);
      end
    void'(expAddr.pop_front());
    void'(expData.pop_front());
    storeCount++;
  endtask

  initial begin
    arstN      <= 1'b0;
    nInstr     = '0;
    nextSlot   = DataBase;
    errCount   = 0;
    storeCount = 0;
    cycleCount = 0;
    for (int i = 0; i < 64; i++) imem[i] = {6'h3f, 26'(i * 4)};  // Unknown opcode, no-op
    for (int i = 0; i < 128; i++) begin
      dmem[i]   = 32'hD00D_0000 ^ 32'(i * 4);
      refMem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) refReg[i] = '0;

    aluImm(OP_ADDI, PoisonReg, 5'd0, 16'h0BAD);
    aluImm(OP_ADDI, 5'd1, 5'd0, 16'd100);
    aluImm(OP_ADDI, 5'd2, 5'd0, 16'hFFF9);    // Negative immediate
    aluReg(OP_ADD, 5'd3, 5'd1, 5'd2);
    storeWord(5'd3);
    aluReg(OP_RSUB, 5'd4, 5'd1, 5'd2);
    storeWord(5'd4);
    aluImm(OP_RSUBI, 5'd5, 5'd1, 16'd40);
    storeWord(5'd5);
    aluImm(OP_ORI, 5'd6, 5'd1, 16'hF00F);
    storeWord(5'd6);
    aluReg(OP_AND, 5'd7, 5'd2, 5'd6);
    storeWord(5'd7);
    aluImm(OP_ANDI, 5'd8, 5'd6, 16'h0FF0);
    storeWord(5'd8);
    aluReg(OP_XOR, 5'd9, 5'd7, 5'd8);
    storeWord(5'd9);
    aluImm(OP_XORI, 5'd10, 5'd9, 16'h5A5A);
    storeWord(5'd10);
    aluReg(OP_OR, 5'd11, 5'd4, 5'd10);
    storeWord(5'd11);
    aluImm(OP_ADDI, 5'd12, 5'd11, 16'd1);     // Dependent chain through the bypass
    aluImm(OP_ADDI, 5'd12, 5'd12, 16'd2);
    aluReg(OP_ADD, 5'd12, 5'd12, 5'd12);
    storeWord(5'd12);
    aluImm(OP_ADDI, 5'd0, 5'd1, 16'd77);      // r0 stays zero
    storeWord(5'd0);
    loadWord(5'd13, nextSlot - 16'd8);        // Reads the r12 slot back
    aluReg(OP_ADD, 5'd14, 5'd13, 5'd13);      // Uses load data at once
    storeWord(5'd14);
    branchOver(OP_BRI, 5'd0, 5'd0);
    aluImm(OP_ADDI, 5'd15, 5'd0, 16'd0);
    branchOver(OP_BCONDI, 5'd0, 5'd15);       // beqi taken
    branchOver(OP_BCONDI, 5'd1, 5'd1);        // bnei taken
    branchOver(OP_BCONDI, 5'd0, 5'd1);        // beqi falls through
    branchOver(OP_BCONDI, 5'd1, 5'd15);       // bnei falls through
    aluImm(OP_ADDI, 5'd16, 5'd0, 16'h1234);
    storeWord(5'd16);

    repeat (8) @(posedge sysClk);
    arstN <= 1'b1;

    // Store retires once both sides are ready
    while (expAddr.size() != 0 && cycleCount < MaxCycles) begin
      @(negedge sysClk);
      cycleCount++;
      if (arstN && dmemReq.en && dmemReq.we && dmemReady && imemReady) begin
        dmem[dmemReq.addr[8:2]] = dmemReq.data;
        checkStore(dmemReq.addr, dmemReq.data);
      end
    end
    if (expAddr.size() != 0) begin
      errCount++;
      $display("Timeout after %0d cycles with %0d stores still missing", cycleCount,
               expAddr.size());
    end
    svaFails = i_aembCore.i_aembCoreSva.failCount;
    $display("Stores checked %0d, store errors %0d, assertion failures %0d", storeCount,
             errCount, svaFails);
    if (errCount == 0 && svaFails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: aembCore.f
+incdir+hw
hw/aembIsaPkg.sv
hw/aembBusPkg.sv
hw/aembFetch.sv
hw/aembDecode.sv
hw/aembRegFile.sv
hw/aembExecute.sv
hw/aembCore.sv
testbench/aembCore_sva.sv
testbench/tbAembCore.sv

// File: run.sh
#!/bin/sh
# Build the AEMB core testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1

TOP=tbAembCore
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f aembCore.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Error limit raised so assertion failures reach the testbench summary
./obj_dir/"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
